/* Bender.yml */
package:
  name: cpu_core

sources:
  - files:
      - rtl/cpu_types_pkg.sv
      - rtl/register_file.sv
      - rtl/pipe_reg.sv
      - rtl/decode.sv
      - rtl/execute.sv
      - rtl/result.sv
      - rtl/cpu_core.sv
  - target: simulation
    files:
      - sim/cpu_core_props.sv
      - sim/cpu_checker.sv
      - sim/tb_cpu_core.sv

/* flist.f */
rtl/cpu_types_pkg.sv
rtl/register_file.sv
rtl/pipe_reg.sv
rtl/decode.sv
rtl/execute.sv
rtl/result.sv
rtl/cpu_core.sv
sim/cpu_core_props.sv
sim/cpu_checker.sv
sim/tb_cpu_core.sv

/* rtl/cpu_core.sv */
// Pipelined integer core
module cpu_core import cpu_types_pkg::*; (
    input  logic    CLK,
    input  logic    nRST,
    input  logic    instr_valid,
    input  word_t   instr,
    output logic    wb_en,
    output regsel_t wb_sel,
    output word_t   wb_data,
    output logic    halted
);

    regsel_t rsel1;
    regsel_t rsel2;
    word_t   rdat1;
    word_t   rdat2;
    id_ex_t  id_payload;
    id_ex_t  id_ex;
    ex_mem_t ex_payload;
    ex_mem_t ex_mem;

    decode u_decode (
        .instr_valid (instr_valid),
        .instr       (instr),
        .halted      (halted),
        .rdat1       (rdat1),
        .rdat2       (rdat2),
        .rsel1       (rsel1),
        .rsel2       (rsel2),
        .id_payload  (id_payload)
    );

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .CLK  (CLK),
        .nRST (nRST),
        .d    (id_payload),
        .q    (id_ex)
    );

    execute u_execute (
        .id_ex      (id_ex),
        .ex_mem     (ex_mem),
        .ex_payload (ex_payload)
    );

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .CLK  (CLK),
        .nRST (nRST),
        .d    (ex_payload),
        .q    (ex_mem)
    );

    result u_result (
        .CLK     (CLK),
        .nRST    (nRST),
        .ex_mem  (ex_mem),
        .wb_en   (wb_en),
        .wb_sel  (wb_sel),
        .wb_data (wb_data),
        .halted  (halted)
    );

    register_file u_rf (
        .CLK   (CLK),
        .nRST  (nRST),
        .rsel1 (rsel1),
        .rsel2 (rsel2),
        .wen   (wb_en),
        .wsel  (wb_sel),
        .wdat  (wb_data),
        .rdat1 (rdat1),
        .rdat2 (rdat2)
    );

endmodule

/* rtl/cpu_types_pkg.sv */
// Pipeline shared types
package cpu_types_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regsel_t;

    // Primary opcodes of the supported subset.
    typedef enum logic [5:0] {
        RTYPE = 6'h00,
        ADDIU = 6'h09,
        SLTI  = 6'h0A,
        ANDI  = 6'h0C,
        ORI   = 6'h0D,
        XORI  = 6'h0E,
        LUI   = 6'h0F,
        HALT  = 6'h3F
    } opcode_t;

    typedef enum logic [5:0] {
        SLL  = 6'h00,
        SRL  = 6'h02,
        ADDU = 6'h21,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        XOR  = 6'h26,
        SLT  = 6'h2A
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7,
        ALU_LUI = 4'd8
    } alu_op_t;

    typedef struct packed {
        alu_op_t     alu_op;
        word_t       rdat1;
        word_t       rdat2;
        regsel_t     rs;
        regsel_t     rt;
        logic [31:0] imm;
        logic        use_imm;
        logic [4:0]  shamt;
        regsel_t     wsel;
        logic        reg_wr;
        logic        halt;
    } id_ex_t;

    typedef struct packed {
        word_t   alu_out;
        regsel_t wsel;
        logic    reg_wr;
        logic    halt;
    } ex_mem_t;

endpackage

/* rtl/decode.sv */
// Instruction decode stage
module decode import cpu_types_pkg::*; (
    input  logic    instr_valid,
    input  word_t   instr,
    input  logic    halted,
    input  word_t   rdat1,
    input  word_t   rdat2,
    output regsel_t rsel1,
    output regsel_t rsel2,
    output id_ex_t  id_payload
);

    opcode_t     opcode;
    funct_t      funct;
    regsel_t     rs;
    regsel_t     rt;
    regsel_t     rd;
    regsel_t     wsel;
    logic [15:0] imm16;
    logic        legal;
    logic        is_halt;
    logic        dest_rd;
    logic        sign_ext;
    logic        live;

    assign opcode = opcode_t'(instr[31:26]);
    assign funct  = funct_t'(instr[5:0]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign imm16  = instr[15:0];

    assign rsel1 = rs;
    assign rsel2 = rt;

    always_comb begin
        id_payload         = '0;
        legal              = 1'b1;
        is_halt            = 1'b0;
        dest_rd            = 1'b0;
        sign_ext           = 1'b0;
        id_payload.use_imm = 1'b1;
        id_payload.alu_op  = ALU_ADD;
        case (opcode)
            RTYPE: begin
                dest_rd            = 1'b1;
                id_payload.use_imm = 1'b0;
                case (funct)
                    SLL:     id_payload.alu_op = ALU_SLL;
                    SRL:     id_payload.alu_op = ALU_SRL;
                    ADDU:    id_payload.alu_op = ALU_ADD;
                    SUBU:    id_payload.alu_op = ALU_SUB;
                    AND:     id_payload.alu_op = ALU_AND;
                    OR:      id_payload.alu_op = ALU_OR;
                    XOR:     id_payload.alu_op = ALU_XOR;
                    SLT:     id_payload.alu_op = ALU_SLT;
                    default: legal = 1'b0;
                endcase
            end
            ADDIU: sign_ext = 1'b1;
            SLTI: begin
                sign_ext          = 1'b1;
                id_payload.alu_op = ALU_SLT;
            end
            ANDI:    id_payload.alu_op = ALU_AND;
            ORI:     id_payload.alu_op = ALU_OR;
            XORI:    id_payload.alu_op = ALU_XOR;
            LUI:     id_payload.alu_op = ALU_LUI;
            HALT:    is_halt = 1'b1;
            default: legal = 1'b0;
        endcase

        wsel = dest_rd ? rd : rt;
        live = instr_valid && !halted && legal;

        id_payload.rdat1  = rdat1;
        id_payload.rdat2  = rdat2;
        id_payload.rs     = rs;
        id_payload.rt     = rt;
        id_payload.imm    = sign_ext ? {{16{imm16[15]}}, imm16} : {16'h0000, imm16};
        id_payload.shamt  = instr[10:6];
        id_payload.wsel   = wsel;
        // Writes to register zero are dropped here so nothing downstream sees them.
        id_payload.reg_wr = live && !is_halt && wsel != '0;
        id_payload.halt   = live && is_halt;
    end

endmodule

/* rtl/execute.sv */
// Execute stage with forwarding
module execute import cpu_types_pkg::*; (
    input  id_ex_t  id_ex,
    input  ex_mem_t ex_mem,
    output ex_mem_t ex_payload
);

    word_t op_a;
    word_t fwd_b;
    word_t op_b;
    word_t alu_out;

    // The instruction just ahead has its result in EX/MEM.
    always_comb begin
        op_a  = id_ex.rdat1;
        fwd_b = id_ex.rdat2;
        if (ex_mem.reg_wr && ex_mem.wsel == id_ex.rs) begin
            op_a = ex_mem.alu_out;
        end
        if (ex_mem.reg_wr && ex_mem.wsel == id_ex.rt) begin
            fwd_b = ex_mem.alu_out;
        end
        op_b = id_ex.use_imm ? id_ex.imm : fwd_b;
    end

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD: alu_out = op_a + op_b;
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_XOR: alu_out = op_a ^ op_b;
            ALU_SLT: alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            // Shifts take rt as the source.
            ALU_SLL: alu_out = op_b << id_ex.shamt;
            ALU_SRL: alu_out = op_b >> id_ex.shamt;
            ALU_LUI: alu_out = {id_ex.imm[15:0], 16'h0000};
            default: alu_out = '0;
        endcase
    end

    always_comb begin
        ex_payload.alu_out = alu_out;
        ex_payload.wsel    = id_ex.wsel;
        ex_payload.reg_wr  = id_ex.reg_wr;
        ex_payload.halt    = id_ex.halt;
    end

endmodule

/* rtl/pipe_reg.sv */
// Pipeline stage latch
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     CLK,
    input  logic     nRST,
    input  payload_t d,
    output payload_t q
);

    // A cleared payload is a bubble.
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

/* rtl/register_file.sv */
// General purpose register file
module register_file import cpu_types_pkg::*; (
    input  logic    CLK,
    input  logic    nRST,
    input  regsel_t rsel1,
    input  regsel_t rsel2,
    input  logic    wen,
    input  regsel_t wsel,
    input  word_t   wdat,
    output word_t   rdat1,
    output word_t   rdat2
);

    // Register zero is not stored.
    word_t regs [31:1];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wsel != '0) begin
            regs[wsel] <= wdat;
        end
    end

    // A write in the same cycle is passed straight to the read port.
    always_comb begin
        if (rsel1 == '0) begin
            rdat1 = '0;
        end else if (wen && wsel == rsel1) begin
            rdat1 = wdat;
        end else begin
            rdat1 = regs[rsel1];
        end
        if (rsel2 == '0) begin
            rdat2 = '0;
        end else if (wen && wsel == rsel2) begin
            rdat2 = wdat;
        end else begin
            rdat2 = regs[rsel2];
        end
    end

endmodule

/* rtl/result.sv */
// Write-back and halt state
module result import cpu_types_pkg::*; (
    input  logic    CLK,
    input  logic    nRST,
    input  ex_mem_t ex_mem,
    output logic    wb_en,
    output regsel_t wb_sel,
    output word_t   wb_data,
    output logic    halted
);

    // Once set, only reset clears it.
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            halted <= 1'b0;
        end else if (ex_mem.halt) begin
            halted <= 1'b1;
        end
    end

    // Instructions already in flight behind a HALT are squashed here.
    assign wb_en   = ex_mem.reg_wr && !halted;
    assign wb_sel  = ex_mem.wsel;
    assign wb_data = ex_mem.alu_out;

endmodule

/* sim/cpu_checker.sv */
// Write-back reference checker
module cpu_checker import cpu_types_pkg::*; (
    input  logic         CLK,
    input  logic         nRST,
    input  logic         instr_valid,
    input  word_t        instr,
    input  logic [127:0] test_tag,
    input  logic         wb_en,
    input  regsel_t      wb_sel,
    input  word_t        wb_data,
    output int           mismatch_count,
    output int           other_errors
);
    timeunit 1ns;
    timeprecision 1ps;

    word_t        model_regs [32];
    logic         model_halted;
    int           cycle;
    regsel_t      exp_sel   [$];
    word_t        exp_data  [$];
    int           exp_cycle [$];
    logic [127:0] exp_tag   [$];
    regsel_t      e_sel;
    word_t        e_data;
    int           e_cycle;
    logic [127:0] e_tag;
    regsel_t      dest;

    initial begin
        mismatch_count = 0;
        other_errors   = 0;
    end

    function automatic logic writes_reg(word_t ins);
        case (ins[31:26])
            RTYPE: begin
                case (ins[5:0])
                    SLL, SRL, ADDU, SUBU, AND, OR, XOR, SLT: return 1'b1;
                    default: return 1'b0;
                endcase
            end
            ADDIU, SLTI, ANDI, ORI, XORI, LUI: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic regsel_t dest_reg(word_t ins);
        return (ins[31:26] == RTYPE) ? ins[15:11] : ins[20:16];
    endfunction

    // Sequential MIPS semantics on the model register file.
    function automatic word_t ref_result(word_t ins);
        word_t a;
        word_t b;
        word_t imm_s;
        word_t imm_z;
        a     = model_regs[ins[25:21]];
        b     = model_regs[ins[20:16]];
        imm_s = {{16{ins[15]}}, ins[15:0]};
        imm_z = {16'h0000, ins[15:0]};
        case (ins[31:26])
            RTYPE: begin
                case (ins[5:0])
                    ADDU: return a + b;
                    SUBU: return a - b;
                    AND:  return a & b;
                    OR:   return a | b;
                    XOR:  return a ^ b;
                    SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    SLL:  return b << ins[10:6];
                    SRL:  return b >> ins[10:6];
                    default: return '0;
                endcase
            end
            ADDIU: return a + imm_s;
            SLTI:  return ($signed(a) < $signed(imm_s)) ? 32'd1 : 32'd0;
            ANDI:  return a & imm_z;
            ORI:   return a | imm_z;
            XORI:  return a ^ imm_z;
            LUI:   return {ins[15:0], 16'h0000};
            default: return '0;
        endcase
    endfunction

    task automatic accept_instr();
        if (instr[31:26] == HALT) begin
            model_halted = 1'b1;
        end else if (writes_reg(instr) && dest_reg(instr) != '0) begin
            dest = dest_reg(instr);
            model_regs[dest] = ref_result(instr);
            exp_sel.push_back(dest);
            exp_data.push_back(model_regs[dest]);
            exp_cycle.push_back(cycle + 2);
            exp_tag.push_back(test_tag);
        end
    endtask

    task automatic compare_write();
        if (exp_sel.size() == 0) begin
            $display("Checker: write to r%0d with no write expected", wb_sel);
            other_errors++;
        end else begin
            e_sel   = exp_sel.pop_front();
            e_data  = exp_data.pop_front();
            e_cycle = exp_cycle.pop_front();
            e_tag   = exp_tag.pop_front();
            if (wb_sel !== e_sel) begin
                $display("Mismatch %0s wb_sel expected %0d actual %0d", e_tag, e_sel, wb_sel);
                mismatch_count++;
            end
            if (wb_data !== e_data) begin
                $display("Mismatch %0s wb_data expected %h actual %h", e_tag, e_data, wb_data);
                mismatch_count++;
            end
            if (cycle != e_cycle) begin
                $display("Mismatch %0s write cycle expected %0d actual %0d",
                         e_tag, e_cycle, cycle);
                mismatch_count++;
            end
        end
    endtask

    task automatic check_drained();
        if (exp_sel.size() != 0) begin
            $display("Checker: %0d expected writes never appeared", exp_sel.size());
            other_errors += exp_sel.size();
        end
    endtask

    // Inputs change on the rising edge, so the falling edge sees stable values.
    always @(negedge CLK) begin
        if (!nRST) begin
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
            model_halted = 1'b0;
            cycle        = 0;
            exp_sel.delete();
            exp_data.delete();
            exp_cycle.delete();
            exp_tag.delete();
        end else begin
            cycle++;
            if (wb_en) begin
                compare_write();
            end
            if (instr_valid && !model_halted) begin
                accept_instr();
            end
        end
    end

endmodule

/* sim/cpu_core_props.sv */
// Core output assertions
module cpu_core_props import cpu_types_pkg::*; (
    input logic    CLK,
    input logic    nRST,
    input logic    wb_en,
    input regsel_t wb_sel,
    input logic    halted
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // Both latches are cleared by reset, so the first cycle after it is quiet.
    wb_quiet_after_reset: assert property (@(posedge CLK) !nRST |=> !wb_en)
        else begin
            fail_count++;
            $error("wb_en is high in the cycle after a reset cycle");
        end

    wb_never_to_zero: assert property (@(posedge CLK) disable iff (!nRST)
        wb_en |-> wb_sel != '0)
        else begin
            fail_count++;
            $error("wb_en is high with wb_sel equal to zero");
        end

    // Halted is sticky and blocks every later write.
    halt_is_final: assert property (@(posedge CLK) disable iff (!nRST)
        halted |-> !wb_en ##1 halted)
        else begin
            fail_count++;
            $error("halted fell, or a write came while halted");
        end

endmodule

bind cpu_core cpu_core_props u_props (
    .CLK    (CLK),
    .nRST   (nRST),
    .wb_en  (wb_en),
    .wb_sel (wb_sel),
    .halted (halted)
);

/* sim/tb_cpu_core.sv */
// Core testbench top
module tb_cpu_core import cpu_types_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    logic         CLK = 1'b0;
    logic         nRST;
    logic         instr_valid;
    word_t        instr;
    logic         wb_en;
    regsel_t      wb_sel;
    word_t        wb_data;
    logic         halted;
    logic [127:0] test_tag;
    logic [127:0] group_name;
    integer       seed = 32'hcb67;
    int           mismatch_count;
    int           other_errors;
    int           timeouts;
    int           assert_fails;
    int           total;
    word_t        rnd_instr;

    always #20 CLK = ~CLK;

    cpu_core u_dut (
        .CLK         (CLK),
        .nRST        (nRST),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_en       (wb_en),
        .wb_sel      (wb_sel),
        .wb_data     (wb_data),
        .halted      (halted)
    );

    cpu_checker u_checker (
        .CLK            (CLK),
        .nRST           (nRST),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .test_tag       (test_tag),
        .wb_en          (wb_en),
        .wb_sel         (wb_sel),
        .wb_data        (wb_data),
        .mismatch_count (mismatch_count),
        .other_errors   (other_errors)
    );

    function automatic word_t r_word(funct_t f, regsel_t rd, regsel_t rs, regsel_t rt,
                                     logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, f};
    endfunction

    function automatic word_t i_word(opcode_t op, regsel_t rt, regsel_t rs, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic send_instr(input word_t ins);
        @(posedge CLK);
        instr_valid <= 1'b1;
        instr       <= ins;
        test_tag    <= group_name;
    endtask

    task automatic idle_for(input int cycles);
        for (int n = 0; n < cycles; n++) begin
            @(posedge CLK);
            instr_valid <= 1'b0;
            instr       <= '0;
        end
    endtask

    task automatic await_halt(input int limit);
        int waited;
        waited = 0;
        while (!halted && waited < limit) begin
            @(negedge CLK);
            waited++;
        end
        if (!halted) begin
            $display("Timeout: halted did not rise within %0d cycles", limit);
            timeouts++;
        end
    endtask

    // Registers r0 to r7 only, so that hazards are frequent.
    task automatic random_instr(output word_t ins);
        int          pick;
        regsel_t     rd;
        regsel_t     rs;
        regsel_t     rt;
        logic [15:0] imm;
        pick = ($random(seed) & 32'h7fffffff) % 14;
        rd   = regsel_t'($random(seed) & 7);
        rs   = regsel_t'($random(seed) & 7);
        rt   = regsel_t'($random(seed) & 7);
        imm  = 16'($random(seed));
        case (pick)
            0:  ins = r_word(ADDU, rd, rs, rt, imm[10:6]);
            1:  ins = r_word(SUBU, rd, rs, rt, imm[10:6]);
            2:  ins = r_word(AND, rd, rs, rt, imm[10:6]);
            3:  ins = r_word(OR, rd, rs, rt, imm[10:6]);
            4:  ins = r_word(XOR, rd, rs, rt, imm[10:6]);
            5:  ins = r_word(SLT, rd, rs, rt, imm[10:6]);
            6:  ins = r_word(SLL, rd, 5'd0, rt, imm[10:6]);
            7:  ins = r_word(SRL, rd, 5'd0, rt, imm[10:6]);
            8:  ins = i_word(ADDIU, rt, rs, imm);
            9:  ins = i_word(SLTI, rt, rs, imm);
            10: ins = i_word(ANDI, rt, rs, imm);
            11: ins = i_word(ORI, rt, rs, imm);
            12: ins = i_word(XORI, rt, rs, imm);
            default: ins = i_word(LUI, rt, rs, imm);
        endcase
    endtask

    initial begin
        nRST        = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        test_tag    = '0;
        timeouts    = 0;
        repeat (2) @(posedge CLK);
        nRST <= 1'b1;

        group_name = "imm_ops";
        send_instr(i_word(ADDIU, 5'd1, 5'd0, 16'h7fff));
        send_instr(i_word(ADDIU, 5'd2, 5'd0, 16'h8000));
        send_instr(i_word(SLTI, 5'd3, 5'd2, 16'h0005));
        send_instr(i_word(SLTI, 5'd4, 5'd1, 16'hffff));
        send_instr(i_word(ANDI, 5'd5, 5'd2, 16'hf0f0));
        send_instr(i_word(ORI, 5'd6, 5'd1, 16'h9234));
        send_instr(i_word(XORI, 5'd7, 5'd1, 16'hffff));
        send_instr(i_word(LUI, 5'd8, 5'd0, 16'habcd));

        group_name = "rtype_ops";
        send_instr(r_word(ADDU, 5'd9, 5'd8, 5'd1, 5'd0));
        send_instr(r_word(SUBU, 5'd10, 5'd1, 5'd2, 5'd0));
        send_instr(r_word(AND, 5'd11, 5'd6, 5'd2, 5'd0));
        send_instr(r_word(OR, 5'd12, 5'd7, 5'd8, 5'd0));
        send_instr(r_word(XOR, 5'd13, 5'd6, 5'd2, 5'd0));
        send_instr(r_word(SLT, 5'd14, 5'd2, 5'd1, 5'd0));
        send_instr(r_word(SLL, 5'd16, 5'd0, 5'd1, 5'd4));
        send_instr(r_word(SRL, 5'd17, 5'd0, 5'd2, 5'd8));

        group_name = "dependency";
        send_instr(i_word(ADDIU, 5'd18, 5'd0, 16'd10));
        send_instr(i_word(ADDIU, 5'd19, 5'd18, 16'd1));
        send_instr(i_word(ADDIU, 5'd20, 5'd0, 16'd3));
        send_instr(r_word(ADDU, 5'd21, 5'd19, 5'd20, 5'd0));
        send_instr(r_word(SLL, 5'd22, 5'd0, 5'd21, 5'd2));

        group_name = "reg_zero";
        send_instr(i_word(ADDIU, 5'd0, 5'd0, 16'h0055));
        send_instr(r_word(ADDU, 5'd0, 5'd1, 5'd1, 5'd0));
        send_instr(i_word(ORI, 5'd25, 5'd0, 16'h0001));
        idle_for(2);

        group_name = "random";
        for (int n = 0; n < 200; n++) begin
            random_instr(rnd_instr);
            send_instr(rnd_instr);
            if (($random(seed) & 3) == 0) begin
                idle_for(1 + ($random(seed) & 3));
            end
        end
        idle_for(3);

        // Instructions right behind the HALT are already in flight.
        group_name = "halt";
        send_instr({HALT, 26'd0});
        send_instr(i_word(ADDIU, 5'd1, 5'd0, 16'h0099));
        send_instr(r_word(ADDU, 5'd3, 5'd1, 5'd1, 5'd0));
        idle_for(1);
        await_halt(20);
        send_instr(i_word(ORI, 5'd5, 5'd0, 16'h0002));
        idle_for(4);

        u_checker.check_drained();
        @(negedge CLK);
        assert_fails = u_dut.u_props.fail_count;
        total = mismatch_count + other_errors + assert_fails + timeouts;
        $display("Error counts: mismatches %0d, checker %0d, assertions %0d, timeouts %0d",
                 mismatch_count, other_errors, assert_fails, timeouts);
        if (total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
